// File: logic/vga_sram_consts.svh
`ifndef VGA_SRAM_CONSTS_SVH
`define VGA_SRAM_CONSTS_SVH

// External SRAM bus
`define SRAM_ADDR_WIDTH 20
`define SRAM_DATA_WIDTH 16

// AXI response code, the only one this design produces
`define AXI_RESP_OKAY 2'b00

// Horizontal raster, in pixel positions
`define H_VISIBLE 8
`define H_SYNC_START 9
`define H_SYNC_END 10
`define H_TOTAL 12

// Vertical raster, in lines
`define V_VISIBLE 4
`define V_SYNC_START 5
`define V_SYNC_END 6
`define V_TOTAL 6

`define FRAME_PIXELS 32

// Pixel FIFO
`define FIFO_DEPTH_LOG2 4
`define FIFO_ALMOST_FULL_LEVEL 12

`endif

// File: logic/vga_sram_pkg.sv
`include "vga_sram_consts.svh"

package vga_sram_pkg;

  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;
  typedef logic [3:0] color_t;
  typedef logic [1:0] axi_resp_t;

  // FIFO word, sync bits on top as they go out to the pins
  typedef struct packed {
    logic hsync;
    logic vsync;
    color_t red;
    color_t green;
    color_t blue;
  } vga_pixel_t;

  // Write address and write data travel on one channel
  typedef struct packed {
    sram_addr_t addr;
    sram_data_t data;
  } axi_write_t;

  typedef struct packed {
    sram_data_t data;
    axi_resp_t resp;
  } axi_read_t;

  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_write,
    ctrl_write_resp,
    ctrl_read,
    ctrl_read_resp
  } ctrl_state_t;

  typedef enum logic [1:0] {pat_fill, pat_wait_resp, pat_done} pattern_state_t;

  typedef enum logic [1:0] {
    stream_advance,
    stream_read_addr,
    stream_read_data,
    stream_push
  } stream_state_t;

endpackage

// File: logic/axi_sram_controller.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module axi_sram_controller (
  input logic clk,
  input logic reset,

  // Write path
  input logic aw_valid,
  output logic aw_ready,
  input vga_sram_pkg::axi_write_t aw_payload,
  output logic b_valid,
  input logic b_ready,
  output vga_sram_pkg::axi_resp_t b_resp,

  // Read path
  input logic ar_valid,
  output logic ar_ready,
  input vga_sram_pkg::sram_addr_t ar_addr,
  output logic r_valid,
  input logic r_ready,
  output vga_sram_pkg::axi_read_t r_payload,

  // SRAM pins
  output vga_sram_pkg::sram_addr_t sram_addr,
  inout wire vga_sram_pkg::sram_data_t sram_data,
  output logic sram_we_n,
  output logic sram_oe_n,
  output logic sram_ce_n
);
  import vga_sram_pkg::*;

  ctrl_state_t state;
  sram_addr_t addr_q;
  sram_data_t wdata_q;
  sram_data_t rdata_q;

  // Only accept new work when idle; writes take priority
  assign aw_ready = (state == ctrl_idle);
  assign ar_ready = (state == ctrl_idle) && !aw_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrl_idle;
    end else begin
      case (state)
        ctrl_idle: begin
          if (aw_valid) begin
            state <= ctrl_write;
          end else if (ar_valid) begin
            state <= ctrl_read;
          end
        end
        ctrl_write: begin
          state <= ctrl_write_resp;
        end
        ctrl_write_resp: begin
          if (b_ready) begin
            state <= ctrl_idle;
          end
        end
        ctrl_read: begin
          state <= ctrl_read_resp;
        end
        ctrl_read_resp: begin
          if (r_ready) begin
            state <= ctrl_idle;
          end
        end
        default: begin
          state <= ctrl_idle;
        end
      endcase
    end
  end

  // Address and data latched at the handshake
  always_ff @(posedge clk) begin
    if (state == ctrl_idle) begin
      if (aw_valid) begin
        addr_q <= aw_payload.addr;
        wdata_q <= aw_payload.data;
      end else if (ar_valid) begin
        addr_q <= ar_addr;
      end
    end
    // Sample at the end of the oe_n low cycle
    if (state == ctrl_read) begin
      rdata_q <= sram_data;
    end
  end

  // SRAM pin sequencing
  assign sram_addr = addr_q;
  assign sram_ce_n = !((state == ctrl_write) || (state == ctrl_read));
  assign sram_we_n = !(state == ctrl_write);
  assign sram_oe_n = !(state == ctrl_read);
  assign sram_data = (state == ctrl_write) ? wdata_q : 'z;

  // Responses held until accepted
  assign b_valid = (state == ctrl_write_resp);
  assign b_resp = `AXI_RESP_OKAY;
  assign r_valid = (state == ctrl_read_resp);
  assign r_payload.data = rdata_q;
  assign r_payload.resp = `AXI_RESP_OKAY;

endmodule

// File: logic/vga_sram_pattern_generator.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module vga_sram_pattern_generator (
  input logic clk,
  input logic reset,
  output logic aw_valid,
  input logic aw_ready,
  output vga_sram_pkg::axi_write_t aw_payload,
  input logic b_valid,
  output logic b_ready,
  input vga_sram_pkg::axi_resp_t b_resp,
  output logic pattern_done
);
  import vga_sram_pkg::*;

  localparam color_t x_last = color_t'(`H_VISIBLE - 1);
  localparam color_t y_last = color_t'(`V_VISIBLE - 1);

  pattern_state_t state;
  color_t x;
  color_t y;
  color_t blue;
  sram_addr_t addr;
  logic last;

  assign last = (x == x_last) && (y == y_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pat_fill;
      x <= '0;
      y <= '0;
      addr <= '0;
    end else begin
      case (state)
        pat_fill: begin
          if (aw_ready) begin
            state <= pat_wait_resp;
          end
        end
        pat_wait_resp: begin
          if (b_valid) begin
            if (b_resp != `AXI_RESP_OKAY) begin
              // Retry the same address
              state <= pat_fill;
            end else if (last) begin
              state <= pat_done;
            end else begin
              state <= pat_fill;
              addr <= addr + 1'b1;
              if (x == x_last) begin
                x <= '0;
                y <= y + 1'b1;
              end else begin
                x <= x + 1'b1;
              end
            end
          end
        end
        default: begin
          state <= pat_done;
        end
      endcase
    end
  end

  // Test image: red is x, green is y, blue wraps x+y
  assign blue = x + y;
  assign aw_payload.addr = addr;
  assign aw_payload.data = {4'b0000, x, y, blue};

  assign aw_valid = (state == pat_fill);
  assign b_ready = (state == pat_wait_resp);
  assign pattern_done = (state == pat_done);

endmodule

// File: logic/vga_sram_pixel_stream.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module vga_sram_pixel_stream (
  input logic clk,
  input logic reset,
  input logic pattern_done,
  input logic almost_full,
  output logic ar_valid,
  input logic ar_ready,
  output vga_sram_pkg::sram_addr_t ar_addr,
  input logic r_valid,
  output logic r_ready,
  input vga_sram_pkg::axi_read_t r_payload,
  output logic push,
  output vga_sram_pkg::vga_pixel_t pixel
);
  import vga_sram_pkg::*;

  localparam int h_bits = $clog2(`H_TOTAL);
  localparam int v_bits = $clog2(`V_TOTAL);

  localparam logic [h_bits-1:0] h_visible = h_bits'(`H_VISIBLE);
  localparam logic [h_bits-1:0] h_sync_start = h_bits'(`H_SYNC_START);
  localparam logic [h_bits-1:0] h_sync_end = h_bits'(`H_SYNC_END);
  localparam logic [h_bits-1:0] h_last = h_bits'(`H_TOTAL - 1);
  localparam logic [v_bits-1:0] v_visible = v_bits'(`V_VISIBLE);
  localparam logic [v_bits-1:0] v_sync_start = v_bits'(`V_SYNC_START);
  localparam logic [v_bits-1:0] v_sync_end = v_bits'(`V_SYNC_END);
  localparam logic [v_bits-1:0] v_last = v_bits'(`V_TOTAL - 1);

  stream_state_t state;
  logic [h_bits-1:0] h_count;
  logic [v_bits-1:0] v_count;
  sram_addr_t fb_addr;
  logic visible;
  logic line_end;
  logic frame_end;

  assign visible = (h_count < h_visible) && (v_count < v_visible);
  assign line_end = (h_count == h_last);
  assign frame_end = line_end && (v_count == v_last);

  // Raster position moves on only after its pixel is pushed
  always_ff @(posedge clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
      fb_addr <= '0;
    end else if (push) begin
      if (line_end) begin
        h_count <= '0;
        v_count <= frame_end ? '0 : v_count + 1'b1;
      end else begin
        h_count <= h_count + 1'b1;
      end
      if (frame_end) begin
        fb_addr <= '0;
      end else if (visible) begin
        fb_addr <= fb_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stream_advance;
    end else begin
      case (state)
        stream_advance: begin
          if (pattern_done && !almost_full) begin
            state <= visible ? stream_read_addr : stream_push;
          end
        end
        stream_read_addr: begin
          if (ar_ready) begin
            state <= stream_read_data;
          end
        end
        stream_read_data: begin
          if (r_valid) begin
            state <= stream_advance;
          end
        end
        default: begin
          state <= stream_advance;
        end
      endcase
    end
  end

  assign ar_valid = (state == stream_read_addr);
  assign ar_addr = fb_addr;
  assign r_ready = (state == stream_read_data);

  // Visible pixels push on the read response itself
  assign push = (state == stream_push) || (r_ready && r_valid);

  always_comb begin
    pixel.hsync = !((h_count >= h_sync_start) && (h_count < h_sync_end));
    pixel.vsync = !((v_count >= v_sync_start) && (v_count < v_sync_end));
    pixel.red = '0;
    pixel.green = '0;
    pixel.blue = '0;
    // A failed read shows as black
    if (r_ready && (r_payload.resp == `AXI_RESP_OKAY)) begin
      pixel.red = r_payload.data[11:8];
      pixel.green = r_payload.data[7:4];
      pixel.blue = r_payload.data[3:0];
    end
  end

endmodule

// File: logic/cdc_fifo.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module cdc_fifo #(
  parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
  input logic w_clk,
  input logic w_reset,
  input logic push,
  input vga_sram_pkg::vga_pixel_t w_data,
  output logic almost_full,
  output logic full,
  input logic r_clk,
  input logic r_reset,
  output vga_sram_pkg::vga_pixel_t r_data
);
  import vga_sram_pkg::*;

  localparam int depth = 2 ** DEPTH_LOG2;
  localparam vga_pixel_t idle_pixel = '{hsync: 1'b1, vsync: 1'b1, red: '0, green: '0, blue: '0};

  // One extra bit tells full from empty
  typedef logic [DEPTH_LOG2:0] ptr_t;

  vga_pixel_t mem [depth];
  ptr_t w_bin, w_bin_next, w_gray, w_rgray_meta, w_rgray, w_rbin, fill;
  ptr_t r_bin, r_bin_next, r_gray, r_wgray_meta, r_wgray;
  logic r_reset_meta, r_reset_sync, r_empty;

  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[DEPTH_LOG2] = gray[DEPTH_LOG2];
    for (int i = DEPTH_LOG2 - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

  // Write side
  assign w_bin_next = w_bin + 1'b1;
  assign w_rbin = gray_to_bin(w_rgray);
  assign fill = w_bin - w_rbin;
  assign full = (fill == ptr_t'(depth));
  assign almost_full = (fill >= ptr_t'(`FIFO_ALMOST_FULL_LEVEL));

  always_ff @(posedge w_clk) begin
    if (w_reset) begin
      w_bin <= '0;
      w_gray <= '0;
      w_rgray_meta <= '0;
      w_rgray <= '0;
    end else begin
      w_rgray_meta <= r_gray;
      w_rgray <= w_rgray_meta;
      if (push && !full) begin
        w_bin <= w_bin_next;
        w_gray <= w_bin_next ^ (w_bin_next >> 1);
      end
    end
  end

  always_ff @(posedge w_clk) begin
    if (push && !full) begin
      mem[w_bin[DEPTH_LOG2-1:0]] <= w_data;
    end
  end

  // Read side, reset brought into pixel clock first
  always_ff @(posedge r_clk) begin
    r_reset_meta <= r_reset;
    r_reset_sync <= r_reset_meta;
  end

  assign r_bin_next = r_bin + 1'b1;
  assign r_empty = (r_gray == r_wgray);

  always_ff @(posedge r_clk) begin
    if (r_reset_sync) begin
      r_bin <= '0;
      r_gray <= '0;
      r_wgray_meta <= '0;
      r_wgray <= '0;
      r_data <= idle_pixel;
    end else begin
      r_wgray_meta <= w_gray;
      r_wgray <= r_wgray_meta;
      if (!r_empty) begin
        r_data <= mem[r_bin[DEPTH_LOG2-1:0]];
        r_bin <= r_bin_next;
        r_gray <= r_bin_next ^ (r_bin_next >> 1);
      end else begin
        r_data <= idle_pixel;
      end
    end
  end

endmodule

// File: logic/vga_sram.sv
`timescale 1ns/1ns

module vga_sram (
  input logic clk,
  input logic pixel_clk,
  input logic reset,

  // SRAM pins
  output vga_sram_pkg::sram_addr_t sram_addr,
  inout wire vga_sram_pkg::sram_data_t sram_data,
  output logic sram_we_n,
  output logic sram_oe_n,
  output logic sram_ce_n,

  // VGA pins
  output vga_sram_pkg::color_t vga_red,
  output vga_sram_pkg::color_t vga_green,
  output vga_sram_pkg::color_t vga_blue,
  output logic vga_hsync,
  output logic vga_vsync
);
  import vga_sram_pkg::*;

  // Write path
  logic aw_valid;
  logic aw_ready;
  axi_write_t aw_payload;
  logic b_valid;
  logic b_ready;
  axi_resp_t b_resp;

  // Read path
  logic ar_valid;
  logic ar_ready;
  sram_addr_t ar_addr;
  logic r_valid;
  logic r_ready;
  axi_read_t r_payload;

  logic pattern_done;
  logic almost_full;
  logic push;
  vga_pixel_t stream_pixel;
  vga_pixel_t vga_pixel;

  axi_sram_controller ctrl (
    .clk(clk),
    .reset(reset),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .aw_payload(aw_payload),
    .b_valid(b_valid),
    .b_ready(b_ready),
    .b_resp(b_resp),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .ar_addr(ar_addr),
    .r_valid(r_valid),
    .r_ready(r_ready),
    .r_payload(r_payload),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n)
  );

  vga_sram_pattern_generator pattern (
    .clk(clk),
    .reset(reset),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .aw_payload(aw_payload),
    .b_valid(b_valid),
    .b_ready(b_ready),
    .b_resp(b_resp),
    .pattern_done(pattern_done)
  );

  vga_sram_pixel_stream pixel_stream (
    .clk(clk),
    .reset(reset),
    .pattern_done(pattern_done),
    .almost_full(almost_full),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .ar_addr(ar_addr),
    .r_valid(r_valid),
    .r_ready(r_ready),
    .r_payload(r_payload),
    .push(push),
    .pixel(stream_pixel)
  );

  // Stream side on clk, pins side on pixel_clk
  cdc_fifo fifo (
    .w_clk(clk),
    .w_reset(reset),
    .push(push),
    .w_data(stream_pixel),
    .almost_full(almost_full),
    .full(),
    .r_clk(pixel_clk),
    .r_reset(reset),
    .r_data(vga_pixel)
  );

  assign vga_hsync = vga_pixel.hsync;
  assign vga_vsync = vga_pixel.vsync;
  assign vga_red = vga_pixel.red;
  assign vga_green = vga_pixel.green;
  assign vga_blue = vga_pixel.blue;

endmodule

// File: testbench/sram_model.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module sram_model #(
  parameter int ADDR_BITS = 6
) (
  input vga_sram_pkg::sram_addr_t addr,
  inout wire vga_sram_pkg::sram_data_t data,
  input logic we_n,
  input logic oe_n,
  input logic ce_n
);
  import vga_sram_pkg::*;

  localparam int words = 2 ** ADDR_BITS;

  // Only the low part of the address space is backed
  sram_data_t mem [words];

  // Bus driven for a read with the write strobe off
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr[ADDR_BITS-1:0]] : 'z;

  // Write taken once address and data have settled inside the strobe
  always @(negedge we_n) begin
    #2;
    if (!ce_n && !we_n && ((addr >> ADDR_BITS) == '0)) begin
      mem[addr[ADDR_BITS-1:0]] = data;
    end
  end

endmodule

// File: testbench/vga_sram_tb.sv
`timescale 1ns/1ns
`include "vga_sram_consts.svh"

module vga_sram_tb;
  import vga_sram_pkg::*;

  localparam int frame_samples = `H_TOTAL * `V_TOTAL;

  logic clk;
  logic pixel_clk;
  logic reset;
  logic pixel_run;

  sram_addr_t sram_addr;
  wire sram_data_t sram_data;
  logic sram_we_n;
  logic sram_oe_n;
  logic sram_ce_n;
  color_t vga_red;
  color_t vga_green;
  color_t vga_blue;
  logic vga_hsync;
  logic vga_vsync;

  // Raster position expected at the next VGA sample
  int h_pos;
  int v_pos;

  vga_sram dut0 (
    .clk(clk),
    .pixel_clk(pixel_clk),
    .reset(reset),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n),
    .vga_red(vga_red),
    .vga_green(vga_green),
    .vga_blue(vga_blue),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  sram_model sram0 (
    .addr(sram_addr),
    .data(sram_data),
    .we_n(sram_we_n),
    .oe_n(sram_oe_n),
    .ce_n(sram_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4;
      clk = !clk;
    end
  end

  // Pixel clock parks low while pixel_run is clear
  initial begin
    pixel_clk = 1'b0;
    forever begin
      #20;
      if (pixel_run || pixel_clk) begin
        pixel_clk = !pixel_clk;
      end
    end
  end

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // Test image word for visible pixel (x, y)
  function automatic sram_data_t image_word(input int x, input int y);
    sram_data_t word;
    word = '0;
    word[11:8] = x[3:0];
    word[7:4] = y[3:0];
    word[3:0] = 4'(x + y);
    return word;
  endfunction

  function automatic vga_pixel_t raster_pixel(input int h, input int v);
    vga_pixel_t p;
    sram_data_t word;
    p.hsync = !((h >= `H_SYNC_START) && (h < `H_SYNC_END));
    p.vsync = !((v >= `V_SYNC_START) && (v < `V_SYNC_END));
    p.red = '0;
    p.green = '0;
    p.blue = '0;
    if ((h < `H_VISIBLE) && (v < `V_VISIBLE)) begin
      word = image_word(h, v);
      p.red = word[11:8];
      p.green = word[7:4];
      p.blue = word[3:0];
    end
    return p;
  endfunction

  task automatic check_idle_pins(input string when);
    check_value(32'(sram_ce_n), 32'd1, {"sram_ce_n ", when});
    check_value(32'(sram_we_n), 32'd1, {"sram_we_n ", when});
    check_value(32'(sram_oe_n), 32'd1, {"sram_oe_n ", when});
    check_value(32'(vga_hsync), 32'd1, {"vga_hsync ", when});
    check_value(32'(vga_vsync), 32'd1, {"vga_vsync ", when});
    check_value(32'({vga_red, vga_green, vga_blue}), 32'd0, {"vga color ", when});
  endtask

  task automatic reset_and_check_idle();
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_idle_pins("during reset");
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_idle_pins("after reset");
  endtask

  task automatic check_frame_fill();
    int writes;
    int cycles;
    writes = 0;
    cycles = 0;
    @(negedge clk);
    while (sram_oe_n !== 1'b0) begin
      if (cycles == 2000) begin
        $display("Timeout: the frame buffer fill never reached its first read");
        stop_with_failure();
      end
      if (sram_we_n === 1'b0) begin
        writes++;
      end
      cycles++;
      @(negedge clk);
    end
    check_value(writes, `FRAME_PIXELS, "write strobes before first read");
    for (int y = 0; y < `V_VISIBLE; y++) begin
      for (int x = 0; x < `H_VISIBLE; x++) begin
        check_value(32'(sram0.mem[y * `H_VISIBLE + x]), 32'(image_word(x, y)),
                    $sformatf("SRAM word at (%0d, %0d)", x, y));
      end
    end
  endtask

  // Sync and color of the pins against the expected position, then step the raster
  task automatic check_sample();
    vga_pixel_t seen;
    seen.hsync = vga_hsync;
    seen.vsync = vga_vsync;
    seen.red = vga_red;
    seen.green = vga_green;
    seen.blue = vga_blue;
    check_value(32'(seen), 32'(raster_pixel(h_pos, v_pos)),
                $sformatf("pixel at (%0d, %0d)", h_pos, v_pos));
    h_pos++;
    if (h_pos == `H_TOTAL) begin
      h_pos = 0;
      v_pos = (v_pos == `V_TOTAL - 1) ? 0 : v_pos + 1;
    end
  endtask

  task automatic check_raster(input int samples, input bit sample_ready);
    for (int i = 0; i < samples; i++) begin
      if (!(sample_ready && (i == 0))) begin
        @(negedge pixel_clk);
      end
      check_sample();
    end
  endtask

  task automatic check_raster_timing();
    int count;
    count = 0;
    @(negedge pixel_clk);
    while (vga_vsync !== 1'b0) begin
      if (count == 1000) begin
        $display("Timeout: vsync never went low on the VGA pins");
        stop_with_failure();
      end
      count++;
      @(negedge pixel_clk);
    end
    // First vsync low sample is the start of the sync line
    h_pos = 0;
    v_pos = `V_SYNC_START;
    check_raster(2 * frame_samples, 1'b1);
  endtask

  task automatic stall_pixel_clock();
    bit full_seen;
    full_seen = 1'b0;
    // Last sample was taken on a falling pixel_clk edge, so the clock parks low
    pixel_run = 1'b0;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      if (dut0.almost_full) begin
        full_seen = 1'b1;
      end
      if (full_seen) begin
        check_value(32'(sram_oe_n), 32'd1, "sram_oe_n while FIFO almost full");
      end
    end
    check_value(32'(full_seen), 32'd1, "FIFO almost full during stall");
    @(posedge clk);
    #1;
    pixel_run = 1'b1;
    check_raster(frame_samples + `H_TOTAL, 1'b0);
  endtask

  initial begin
    pixel_run = 1'b1;
    reset = 1'b1;
    h_pos = 0;
    v_pos = 0;
    reset_and_check_idle();
    check_frame_fill();
    check_raster_timing();
    stall_pixel_clock();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
logic/vga_sram_pkg.sv
logic/axi_sram_controller.sv
logic/vga_sram_pattern_generator.sv
logic/vga_sram_pixel_stream.sv
logic/cdc_fifo.sv
logic/vga_sram.sv
testbench/sram_model.sv
testbench/vga_sram_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module vga_sram_tb -f build.f -o vga_sram_sim

sim_output=$(./obj_dir/vga_sram_sim) || {
  echo "$sim_output"
  exit 1
}
echo "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
